// File: hdl/div_types_pkg.sv
package div_types_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // operand widths
  // ~~~~~~~~~~~~~~~~~~~~

  localparam int dividend_w = 16;  // the dividend is two bytes wide

  // quotient and remainder share the divisor width
  localparam int divisor_w = 8;

  // ~~~~~~~~~~~~~~~~~~~~
  // array geometry
  // ~~~~~~~~~~~~~~~~~~~~

  localparam int row_count = divisor_w;  // each row yields one quotient bit

  // rows counted from the bottom that use the approximate cell
  localparam int default_approx_rows = 2;

endpackage

// File: hdl/div_cell_pkg.sv
package div_cell_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // cell kinds
  // ~~~~~~~~~~~~~~~~~~~~

  typedef enum logic {
    cell_exact,   // plain full subtractor
    cell_approx   // subtractor with two wrong difference entries
  } cell_kind_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // truth tables
  // ~~~~~~~~~~~~~~~~~~~~

  // every table is indexed by {x, y, borrow_in} and bit i holds the output for input i

  localparam logic [7:0] exact_diff_table   = 8'b1001_0110;  // x ^ y ^ borrow_in
  localparam logic [7:0] exact_borrow_table = 8'b1000_1110;  // set for 001, 010, 011 and 111

  // the approximate borrow keeps the exact behaviour
  localparam logic [7:0] approx_borrow_table = 8'b1000_1110;

  // difference is wrong at 001 (reads 0) and at 101 (reads 1)
  localparam logic [7:0] approx_diff_table = 8'b1011_0100;

endpackage

// File: hdl/div_cell.sv
`timescale 1ns/100ps

module div_cell #(
  parameter div_cell_pkg::cell_kind_t kind = div_cell_pkg::cell_exact
) (
  input  logic x,
  input  logic y,
  input  logic borrow_in,
  input  logic sel,
  output logic diff_sel,
  output logic borrow_out
);

  import div_cell_pkg::*;

  // the kind is fixed at elaboration so only one table pair is built
  localparam logic [7:0] diff_table   = (kind == cell_approx) ? approx_diff_table
                                                              : exact_diff_table;
  localparam logic [7:0] borrow_table = (kind == cell_approx) ? approx_borrow_table
                                                              : exact_borrow_table;

  logic [2:0] idx;
  logic       diff;

  assign idx = {x, y, borrow_in};

  assign diff       = diff_table[idx];
  assign borrow_out = borrow_table[idx];  // the borrow never looks at sel

  // a cleared quotient bit restores the remainder bit
  assign diff_sel = sel ? diff : x;

endmodule

// File: hdl/div_array_row.sv
`timescale 1ns/100ps

module div_array_row #(
  parameter div_cell_pkg::cell_kind_t kind = div_cell_pkg::cell_exact
) (
  input  logic [div_types_pkg::divisor_w:0]   window,
  input  logic [div_types_pkg::divisor_w-1:0] divisor,
  output logic                                quot_bit,
  output logic [div_types_pkg::divisor_w-1:0] rem_out
);

  import div_types_pkg::*;

  // borrow[j] enters cell j and borrow[divisor_w] leaves the row
  logic borrow [0:divisor_w];

  assign borrow[0] = 1'b0;

  // ~~~~~~~~~~~~~~~~~~~~
  // cell chain
  // ~~~~~~~~~~~~~~~~~~~~

  for (genvar j = 0; j < divisor_w; j++) begin : g_cell
    div_cell #(
      .kind (kind)
    ) u_cell (
      .x          (window[j]),
      .y          (divisor[j]),
      .borrow_in  (borrow[j]),
      .sel        (quot_bit),
      .diff_sel   (rem_out[j]),
      .borrow_out (borrow[j+1])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // quotient decision
  // ~~~~~~~~~~~~~~~~~~~~

  // a set top bit means the window already exceeds any divisor
  assign quot_bit = window[divisor_w] | ~borrow[divisor_w];

endmodule

// File: hdl/div_array.sv
`timescale 1ns/100ps

module div_array #(
  parameter int approx_rows = div_types_pkg::default_approx_rows
) (
  input  logic [div_types_pkg::dividend_w-1:0] dividend,
  input  logic [div_types_pkg::divisor_w-1:0]  divisor,
  output logic [div_types_pkg::divisor_w-1:0]  quotient,
  output logic [div_types_pkg::divisor_w-1:0]  remainder
);

  import div_types_pkg::*;
  import div_cell_pkg::*;

  logic [divisor_w:0]   row_window [0:row_count-1];  // partial remainder seen by each row
  logic [divisor_w-1:0] row_rem    [0:row_count-1];  // restored remainder leaving each row

  // ~~~~~~~~~~~~~~~~~~~~
  // row stack
  // ~~~~~~~~~~~~~~~~~~~~

  for (genvar k = 0; k < row_count; k++) begin : g_row
    // the lowest approx_rows rows trade accuracy for a smaller cell
    localparam cell_kind_t row_kind = (k < approx_rows) ? cell_approx : cell_exact;

    if (k == row_count - 1) begin : g_top
      // the top row sees the upper nine dividend bits directly
      assign row_window[k] = dividend[dividend_w-1 -: divisor_w+1];
    end else begin : g_lower
      assign row_window[k] = {row_rem[k+1], dividend[k]};  // shift in the next dividend bit
    end

    div_array_row #(
      .kind (row_kind)
    ) u_row (
      .window   (row_window[k]),
      .divisor  (divisor),
      .quot_bit (quotient[k]),
      .rem_out  (row_rem[k])
    );
  end

  // the bottom row holds the final remainder
  assign remainder = row_rem[0];

endmodule

// File: hdl/div_pipe.sv
`timescale 1ns/100ps

module div_pipe #(
  parameter int approx_rows = div_types_pkg::default_approx_rows
) (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 start,
  input  logic [div_types_pkg::dividend_w-1:0] dividend,
  input  logic [div_types_pkg::divisor_w-1:0]  divisor,
  output logic                                 done,
  output logic [div_types_pkg::divisor_w-1:0]  quotient,
  output logic [div_types_pkg::divisor_w-1:0]  remainder,
  output logic                                 div_zero,
  output logic                                 overflow
);

  import div_types_pkg::*;

  logic                  s1_valid;
  logic [dividend_w-1:0] s1_dividend;
  logic [divisor_w-1:0]  s1_divisor;

  logic [divisor_w-1:0] high_byte;
  logic [divisor_w-1:0] arr_quotient;
  logic [divisor_w-1:0] arr_remainder;
  logic                 zero_det;
  logic                 range_det;

  // ~~~~~~~~~~~~~~~~~~~~
  // input stage
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= start;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      s1_dividend <= dividend;
      s1_divisor  <= divisor;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // array and range check
  // ~~~~~~~~~~~~~~~~~~~~

  div_array #(
    .approx_rows (approx_rows)
  ) u_array (
    .dividend  (s1_dividend),
    .divisor   (s1_divisor),
    .quotient  (arr_quotient),
    .remainder (arr_remainder)
  );

  assign high_byte = s1_dividend[dividend_w-1 -: divisor_w];
  assign zero_det  = (s1_divisor == '0);
  assign range_det = !zero_det && (high_byte >= s1_divisor);  // quotient would not fit

  // ~~~~~~~~~~~~~~~~~~~~
  // output stage
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (reset) begin
      done      <= 1'b0;
      div_zero  <= 1'b0;
      overflow  <= 1'b0;
      quotient  <= '0;
      remainder <= '0;
    end else begin
      done <= s1_valid;  // a result not taken is simply overwritten
      if (s1_valid) begin
        div_zero <= zero_det;
        overflow <= range_det;
        if (zero_det || range_det) begin
          quotient  <= '1;
          remainder <= s1_dividend[divisor_w-1:0];
        end else begin
          quotient  <= arr_quotient;
          remainder <= arr_remainder;
        end
      end
    end
  end

  // a done pulse always traces back to a start two edges earlier
  a_no_spurious_done: assert property (@(posedge clk) disable iff (reset)
    !start |-> ##2 !done);

  a_zero_priority: assert property (@(posedge clk) disable iff (reset)
    div_zero |-> !overflow);

  if (approx_rows == 0) begin : g_exact_check
    // the operands behind a result sat in the input stage one edge before it
    a_exact_identity: assert property (@(posedge clk) disable iff (reset)
      (done && !div_zero && !overflow) |->
      (dividend_w'(quotient) * dividend_w'($past(s1_divisor)) + dividend_w'(remainder)
        == $past(s1_dividend)));
  end

endmodule

// File: dv/div_model.svh
`ifndef DIV_MODEL_SVH
`define DIV_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~
// cell lookups
// ~~~~~~~~~~~~~~~~~~~~

function automatic logic lookup_cell_diff(input div_cell_pkg::cell_kind_t kind,
                                          input logic [2:0] idx);
  if (kind == div_cell_pkg::cell_approx) begin
    return div_cell_pkg::approx_diff_table[idx];
  end
  return div_cell_pkg::exact_diff_table[idx];
endfunction

function automatic logic lookup_cell_borrow(input div_cell_pkg::cell_kind_t kind,
                                            input logic [2:0] idx);
  if (kind == div_cell_pkg::cell_approx) begin
    return div_cell_pkg::approx_borrow_table[idx];
  end
  return div_cell_pkg::exact_borrow_table[idx];
endfunction

// ~~~~~~~~~~~~~~~~~~~~
// array walk
// ~~~~~~~~~~~~~~~~~~~~

// returns {quotient, remainder} as the array would form them
function automatic logic [2*div_types_pkg::divisor_w-1:0] walk_array(
  input logic [div_types_pkg::dividend_w-1:0] dividend,
  input logic [div_types_pkg::divisor_w-1:0]  divisor,
  input int                                   approx_rows
);
  logic [div_types_pkg::divisor_w:0]   window;
  logic [div_types_pkg::divisor_w-1:0] rem;
  logic [div_types_pkg::divisor_w-1:0] quo;
  logic [div_types_pkg::divisor_w-1:0] diff;
  logic [2:0]                          idx;
  logic                                borrow;
  div_cell_pkg::cell_kind_t            kind;
  window = dividend[div_types_pkg::dividend_w-1 -: div_types_pkg::divisor_w+1];
  rem    = '0;
  quo    = '0;
  for (int k = div_types_pkg::row_count - 1; k >= 0; k--) begin
    if (k != div_types_pkg::row_count - 1) begin
      window = {rem, dividend[k]};
    end
    kind   = (k < approx_rows) ? div_cell_pkg::cell_approx : div_cell_pkg::cell_exact;
    borrow = 1'b0;
    for (int j = 0; j < div_types_pkg::divisor_w; j++) begin
      idx     = {window[j], divisor[j], borrow};
      diff[j] = lookup_cell_diff(kind, idx);
      borrow  = lookup_cell_borrow(kind, idx);
    end
    quo[k] = window[div_types_pkg::divisor_w] | ~borrow;
    rem    = quo[k] ? diff : window[div_types_pkg::divisor_w-1:0];
  end
  return {quo, rem};
endfunction

// ~~~~~~~~~~~~~~~~~~~~
// range rule
// ~~~~~~~~~~~~~~~~~~~~

function automatic logic is_zero_divisor(input logic [div_types_pkg::divisor_w-1:0] divisor);
  return divisor == '0;
endfunction

function automatic logic is_out_of_range(input logic [div_types_pkg::dividend_w-1:0] dividend,
                                         input logic [div_types_pkg::divisor_w-1:0]  divisor);
  // divide-by-zero wins, so overflow stays low for a zero divisor
  return (divisor != '0) &&
         (dividend[div_types_pkg::dividend_w-1 -: div_types_pkg::divisor_w] >= divisor);
endfunction

// full expected result as {quotient, remainder} including the error substitution
function automatic logic [2*div_types_pkg::divisor_w-1:0] expected_result(
  input logic [div_types_pkg::dividend_w-1:0] dividend,
  input logic [div_types_pkg::divisor_w-1:0]  divisor,
  input int                                   approx_rows
);
  if (is_zero_divisor(divisor) || is_out_of_range(dividend, divisor)) begin
    return {{div_types_pkg::divisor_w{1'b1}}, dividend[div_types_pkg::divisor_w-1:0]};
  end
  return walk_array(dividend, divisor, approx_rows);
endfunction

`endif

// File: dv/div_tb.sv
`timescale 1ns/100ps

module div_tb #(
  parameter int approx_rows = div_types_pkg::default_approx_rows
);

  import div_types_pkg::*;

  `include "div_model.svh"

  localparam int clk_period   = 20;
  localparam int reset_cycles = 16;
  localparam int burst_len    = 200;
  localparam int exact_len    = 100;
  localparam int max_cycles   = 2000;  // well above the ~370 cycles the exact build takes

  logic                  clk;
  logic                  reset;
  logic                  start;
  logic [dividend_w-1:0] dividend;
  logic [divisor_w-1:0]  divisor;
  logic                  done;
  logic [divisor_w-1:0]  quotient;
  logic [divisor_w-1:0]  remainder;
  logic                  div_zero;
  logic                  overflow;

  int cycle_count = 0;

  logic [dividend_w-1:0] pend_dividend [$];  // operations waiting to be issued
  logic [divisor_w-1:0]  pend_divisor  [$];
  logic [dividend_w-1:0] fl_dividend   [$];  // operations in flight
  logic [divisor_w-1:0]  fl_divisor    [$];
  int                    fl_due        [$];  // cycle on which each done is due

  div_pipe #(
    .approx_rows (approx_rows)
  ) dut (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .dividend  (dividend),
    .divisor   (divisor),
    .done      (done),
    .quotient  (quotient),
    .remainder (remainder),
    .div_zero  (div_zero),
    .overflow  (overflow)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      $display("Test failed");
      $fatal(1);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // checking helpers
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic stop_with_error(input string msg);
    $display("ERROR: %s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic queue_op(input logic [dividend_w-1:0] a, input logic [divisor_w-1:0] b);
    pend_dividend.push_back(a);
    pend_divisor.push_back(b);
  endtask

  // issues the queued operations with gap idle cycles between them and checks each done
  task automatic run_sequence(input string name, input int gap, input bit identity);
    int                     n;
    int                     seen;
    logic [2*divisor_w-1:0] expect_qr;
    n    = pend_dividend.size();
    seen = 0;
    fork
      begin
        for (int i = 0; i < n; i++) begin
          @(posedge clk);
          #2;
          start    = 1'b1;
          dividend = pend_dividend[i];
          divisor  = pend_divisor[i];
          fl_dividend.push_back(pend_dividend[i]);
          fl_divisor.push_back(pend_divisor[i]);
          fl_due.push_back(cycle_count + 2);  // sampled on the next edge, done one edge later
          repeat (gap) begin
            @(posedge clk);
            #2;
            start = 1'b0;
          end
        end
        @(posedge clk);
        #2;
        start = 1'b0;
      end
      begin
        while (seen < n) begin
          @(negedge clk);
          if (done) begin
            if (fl_due.size() == 0) begin
              stop_with_error({name, ": done was raised without a matching start"});
            end else begin
              expect_qr = expected_result(fl_dividend[0], fl_divisor[0], approx_rows);
              check_value({name, " done cycle"}, 32'(fl_due[0]), 32'(cycle_count));
              check_value({name, " quotient"}, 32'(expect_qr[2*divisor_w-1 -: divisor_w]),
                          32'(quotient));
              check_value({name, " remainder"}, 32'(expect_qr[divisor_w-1:0]),
                          32'(remainder));
              check_value({name, " div_zero"}, 32'(is_zero_divisor(fl_divisor[0])),
                          32'(div_zero));
              check_value({name, " overflow"},
                          32'(is_out_of_range(fl_dividend[0], fl_divisor[0])), 32'(overflow));
              if (identity) begin
                check_value({name, " identity"}, 32'(fl_dividend[0]),
                            32'(quotient) * 32'(fl_divisor[0]) + 32'(remainder));
                check_value({name, " remainder below divisor"}, 32'd1,
                            32'(remainder < fl_divisor[0]));
              end
              void'(fl_dividend.pop_front());
              void'(fl_divisor.pop_front());
              void'(fl_due.pop_front());
              seen++;
            end
          end else if (fl_due.size() > 0 && fl_due[0] <= cycle_count) begin
            stop_with_error({name, ": done did not arrive two edges after start"});
          end
        end
      end
    join
    pend_dividend.delete();
    pend_divisor.delete();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // directed tests
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic idle_after_reset();
    repeat (8) begin
      @(negedge clk);
      check_value("reset idle done", 32'd0, 32'(done));
      check_value("reset idle div_zero", 32'd0, 32'(div_zero));
      check_value("reset idle overflow", 32'd0, 32'(overflow));
      check_value("reset idle quotient", 32'd0, 32'(quotient));
      check_value("reset idle remainder", 32'd0, 32'(remainder));
    end
  endtask

  // the chosen operands never hand an approximate row a wrong difference it keeps
  task automatic exact_case(input string name, input logic [dividend_w-1:0] a,
                            input logic [divisor_w-1:0] b);
    logic [2*divisor_w-1:0] exact_qr;
    exact_qr = expected_result(a, b, 0);
    check_value({name, " model paths agree"}, 32'(exact_qr),
                32'(expected_result(a, b, approx_rows)));
    check_value({name, " true quotient"}, 32'(a / 16'(b)),
                32'(exact_qr[2*divisor_w-1 -: divisor_w]));
    check_value({name, " true remainder"}, 32'(a % 16'(b)), 32'(exact_qr[divisor_w-1:0]));
    queue_op(a, b);
  endtask

  task automatic exact_operands();
    exact_case("exact 0/7", 16'd0, 8'd7);
    exact_case("exact 3/1", 16'd3, 8'd1);
    exact_case("exact 181/1", 16'd181, 8'd1);
    exact_case("exact 896/7", 16'd896, 8'd7);
    exact_case("exact 900/7", 16'd900, 8'd7);
    run_sequence("exact cases", 1, 1'b0);
  endtask

  task automatic random_burst(input string name, input int n, input bit identity);
    logic [divisor_w-1:0] b;
    logic [divisor_w-1:0] high;
    for (int i = 0; i < n; i++) begin
      b    = 8'($urandom_range(255, 1));
      high = 8'($urandom_range(32'(b) - 1, 0));  // keeps the quotient in range
      queue_op({high, 8'($urandom)}, b);
    end
    run_sequence(name, 0, identity);
  endtask

  task automatic zero_divisor_cases();
    queue_op(16'h1234, 8'h00);
    queue_op(16'h00ff, 8'h00);
    queue_op(16'hffff, 8'h00);
    run_sequence("divide by zero", 0, 1'b0);
  endtask

  task automatic overflow_with_gaps();
    queue_op(16'h0505, 8'h05);
    queue_op(16'h0a00, 8'h05);
    queue_op(16'hff00, 8'h01);
    queue_op(16'h80ff, 8'h80);
    run_sequence("overflow with gaps", 3, 1'b0);
  endtask

  task automatic exact_build_identity();
    if (approx_rows == 0) begin
      random_burst("exact build identity", exact_len, 1'b1);
    end else begin
      $display("note: identity test runs only in the build with approx_rows = 0");
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // main sequence
  // ~~~~~~~~~~~~~~~~~~~~

  initial begin
    void'($urandom(32'h03da3505));
    reset    = 1'b1;
    start    = 1'b0;
    dividend = '0;
    divisor  = '0;
    repeat (reset_cycles) @(posedge clk);
    #2;
    reset = 1'b0;

    idle_after_reset();
    exact_operands();
    random_burst("random burst", burst_len, 1'b0);
    zero_divisor_cases();
    overflow_with_gaps();
    exact_build_identity();

    repeat (4) @(posedge clk);
    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: sources.f
+incdir+dv
hdl/div_types_pkg.sv
hdl/div_cell_pkg.sv
hdl/div_cell.sv
hdl/div_array_row.sv
hdl/div_array.sv
hdl/div_pipe.sv
dv/div_tb.sv

// File: Makefile
# Verilator build for the pipelined array divider

VERILATOR   ?= verilator
TOP         ?= div_tb
RTL_TOP     ?= div_pipe
FILELIST    ?= sources.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
APPROX_ROWS ?= 2
EXTRA_FLAGS ?=

EXACT_DIR ?= obj_dir_exact
EXACT_LOG ?= sim_exact.log

PASS_MSG := Test completed successfully

VFLAGS = --binary --timing --assert -j 0 \
         --top-module $(TOP) -Gapprox_rows=$(APPROX_ROWS) \
         --Mdir $(BUILD_DIR) -f $(FILELIST) $(EXTRA_FLAGS)

.PHONY: all build run exact lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS: $(LOG)"; \
	else \
		echo "FAIL: see $(LOG)"; \
		exit 1; \
	fi

# exact build with no approximate rows
exact:
	$(MAKE) run APPROX_ROWS=0 BUILD_DIR=$(EXACT_DIR) LOG=$(EXACT_LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(EXACT_DIR) $(LOG) $(EXACT_LOG)
